// File: source/mrd_params.svh
//--------------------
// mixed-radix DFT parameter generator
// widths and stage count shared by package and RTL
//--------------------
`ifndef MRD_PARAMS_SVH
`define MRD_PARAMS_SVH

// point count, up to 4095 points
`define MRD_PTS_W 12

// radix factor code, values 1..5
`define MRD_FACTOR_W 3

// butterfly stages per transform
`define MRD_STAGES 6

// size index and table word
`define MRD_SIZE_IDX_W 6
`define MRD_ROM_W 64

`endif

// File: source/mrd_pkg.sv
//--------------------
// mixed-radix DFT parameter generator
// shared types for points, factors and table words
//--------------------
`include "mrd_params.svh"

package mrd_pkg;

	// single point count
	typedef logic [`MRD_PTS_W-1:0] pts_t;

	// single radix factor
	typedef logic [`MRD_FACTOR_W-1:0] factor_t;

	// one factor per stage, stage 0 in the low bits
	typedef logic [`MRD_STAGES-1:0][`MRD_FACTOR_W-1:0] factor_vec_t;

	// one point count per stage
	typedef logic [`MRD_STAGES-1:0][`MRD_PTS_W-1:0] pts_vec_t;

	// size table word
	typedef logic [`MRD_ROM_W-1:0] rom_word_t;

	// transform size selector
	typedef logic [`MRD_SIZE_IDX_W-1:0] size_idx_t;

endpackage

// File: source/mrd_size_rom.sv
//--------------------
// size table front end
// sop delay line, two-word address sequencing and
// registered size table with load strobes
//--------------------
`timescale 1ns/10ps
`include "mrd_params.svh"

module mrd_size_rom
	import mrd_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      sink_sop,
	input  size_idx_t size,
	output rom_word_t rom_q,
	output logic      load_cfg,
	output logic      load_aux
);

	// sop taps, [0] one cycle late .. [3] four cycles late
	logic [3:0] sop_q;
	// {size index, word select}
	logic [`MRD_SIZE_IDX_W:0] rd_addr;
	rom_word_t rom_rd;

	// word 0: size, base, factors 5..1, factor count
	function automatic rom_word_t cfg_word(input pts_t sz, input pts_t base,
		input factor_t f1, input factor_t f2, input factor_t f3,
		input factor_t f4, input factor_t f5);
		factor_t num;
		// stage 0 is always radix 4
		num = 3'd1 + factor_t'(f1 != 3'd1) + factor_t'(f2 != 3'd1) +
			factor_t'(f3 != 3'd1) + factor_t'(f4 != 3'd1) + factor_t'(f5 != 3'd1);
		cfg_word = {22'd0, num, f1, f2, f3, f4, f5, base, sz};
	endfunction

	// word 1: radix-2 stage and factor-5 flag
	function automatic rom_word_t aux_word(input logic f5_flag, input factor_t rdx2);
		aux_word = {60'd0, rdx2, f5_flag};
	endfunction

	function automatic rom_word_t table_word(input logic [`MRD_SIZE_IDX_W:0] a);
		case (a)
			{6'd0, 1'b0}: table_word = cfg_word(12'd1200, 12'd80, 3'd4, 3'd5, 3'd5, 3'd3, 3'd1);
			{6'd0, 1'b1}: table_word = aux_word(1'b1, 3'd7);
			{6'd1, 1'b0}: table_word = cfg_word(12'd1152, 12'd384, 3'd4, 3'd4, 3'd2, 3'd3, 3'd3);
			{6'd1, 1'b1}: table_word = aux_word(1'b0, 3'd3);
			{6'd2, 1'b0}: table_word = cfg_word(12'd960, 12'd64, 3'd4, 3'd4, 3'd5, 3'd3, 3'd1);
			{6'd2, 1'b1}: table_word = aux_word(1'b1, 3'd7);
			{6'd3, 1'b0}: table_word = cfg_word(12'd600, 12'd40, 3'd2, 3'd5, 3'd5, 3'd3, 3'd1);
			{6'd3, 1'b1}: table_word = aux_word(1'b1, 3'd1);
			{6'd4, 1'b0}: table_word = cfg_word(12'd12, 12'd4, 3'd3, 3'd1, 3'd1, 3'd1, 3'd1);
			{6'd4, 1'b1}: table_word = aux_word(1'b0, 3'd7);
			// unsupported sizes read back as zero
			default:      table_word = '0;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sop_q <= '0;
		end else begin
			sop_q <= {sop_q[2:0], sink_sop};
		end
	end

	// word 0 on sop, word 1 next cycle, size index held
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_addr <= '0;
		end else if (sink_sop) begin
			rd_addr <= {size, 1'b0};
		end else if (sop_q[0]) begin
			rd_addr <= {rd_addr[`MRD_SIZE_IDX_W:1], 1'b1};
		end
	end

	// table read plus output register, two-cycle read
	always_ff @(posedge clk) begin
		rom_rd <= table_word(rd_addr);
		rom_q  <= rom_rd;
	end

	// falling edges of the late taps line up with words 0 and 1
	assign load_cfg = sop_q[2] & ~sop_q[1];
	assign load_aux = sop_q[3] & ~sop_q[2];

endmodule

// File: source/mrd_factor_latch.sv
//--------------------
// factor latch
// captures table words into factor, size and base registers
//--------------------
`timescale 1ns/10ps
`include "mrd_params.svh"

module mrd_factor_latch
	import mrd_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  rom_word_t   rom_q,
	input  logic        load_cfg,
	input  logic        load_aux,
	output factor_vec_t nf,
	output factor_t     num_of_factors,
	output factor_t     stage_of_rdx2,
	output pts_t        dft_size,
	output pts_t        div_base,
	output logic        factor_5,
	output logic        calc_start
);

	// first stage is always radix 4
	localparam factor_t FIRST_FACTOR = 3'd4;

	// stages 1..5 come from the table
	logic [`MRD_STAGES-1:1][`MRD_FACTOR_W-1:0] nf_q;

	// ---- word 0 ----
	// nf[5] sits lowest, at bit 24
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			nf_q           <= '0;
			num_of_factors <= '0;
			dft_size       <= '0;
			div_base       <= '0;
		end else if (load_cfg) begin
			dft_size <= rom_q[11:0];
			div_base <= rom_q[23:12];
			for (int k = 1; k < `MRD_STAGES; k++) begin
				nf_q[k] <= rom_q[24 + 3*(`MRD_STAGES-1-k) +: 3];
			end
			num_of_factors <= rom_q[41:39];
		end
	end

	// ---- word 1 ----
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			factor_5      <= 1'b0;
			stage_of_rdx2 <= '0;
			calc_start    <= 1'b0;
		end else begin
			// all fields settled, kick off the calculators
			calc_start <= load_aux;
			if (load_aux) begin
				factor_5      <= rom_q[0];
				stage_of_rdx2 <= rom_q[3:1];
			end
		end
	end

	assign nf = {nf_q, FIRST_FACTOR};

endmodule

// File: source/mrd_stride_calc.sv
//--------------------
// points per butterfly group
// DFT size divided by each stage's factor
//--------------------
`timescale 1ns/10ps
`include "mrd_params.svh"

module mrd_stride_calc
	import mrd_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        calc_start,
	input  factor_vec_t nf,
	input  pts_t        dft_size,
	input  pts_t        div_base,
	input  logic        factor_5,
	output pts_vec_t    dftpts_div_nf
);

	pts_t quarter;
	pts_t half;
	pts_t base_x3;
	pts_t base_x5;

	// base is N/3, or N/15 when 5 divides the size
	assign quarter = dft_size >> 2;
	assign half    = dft_size >> 1;
	assign base_x3 = div_base + (div_base << 1);
	assign base_x5 = div_base + (div_base << 2);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dftpts_div_nf <= '0;
		end else if (calc_start) begin
			// stage 0 is radix 4 regardless of table
			dftpts_div_nf[0] <= quarter;
			for (int j = 1; j < `MRD_STAGES; j++) begin
				case (nf[j])
					3'd4:    dftpts_div_nf[j] <= quarter;
					3'd2:    dftpts_div_nf[j] <= half;
					3'd3:    dftpts_div_nf[j] <= factor_5 ? base_x5 : div_base;
					3'd5:    dftpts_div_nf[j] <= base_x3;
					// unused stage
					default: dftpts_div_nf[j] <= '0;
				endcase
			end
		end
	end

endmodule

// File: source/mrd_twiddle_chain.sv
//--------------------
// twiddle denominators
// running product of factors, last stage first,
// one stage per cycle
//--------------------
`timescale 1ns/10ps
`include "mrd_params.svh"

module mrd_twiddle_chain
	import mrd_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        calc_start,
	input  factor_vec_t nf,
	input  pts_t        dft_size,
	output pts_vec_t    twdl_demontr
);

	localparam int LAST = `MRD_STAGES - 1;

	// calc_start delayed, one tap per remaining stage
	logic [LAST-3:0] tap;
	pts_t den_q [1:LAST];

	// v times factor, shifts and adds only
	function automatic pts_t mul_factor(input pts_t v, input factor_t f);
		case (f)
			3'd2:    mul_factor = v << 1;
			3'd3:    mul_factor = v + (v << 1);
			3'd4:    mul_factor = v << 2;
			3'd5:    mul_factor = v + (v << 2);
			// factor 1 passes through
			default: mul_factor = v;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tap <= '0;
		end else begin
			tap <= {tap[LAST-4:0], calc_start};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 1; k <= LAST; k++) begin
				den_q[k] <= '0;
			end
		end else begin
			// top two stages straight from the factors
			if (calc_start) begin
				den_q[LAST]   <= pts_t'(nf[LAST]);
				den_q[LAST-1] <= mul_factor(pts_t'(nf[LAST]), nf[LAST-1]);
			end
			// walk down, stage 3 on tap 0 .. stage 1 on tap 2
			for (int k = 1; k <= LAST-2; k++) begin
				if (tap[LAST-2-k]) begin
					den_q[k] <= mul_factor(den_q[k+1], nf[k]);
				end
			end
		end
	end

	// entry 0 is the full size
	always_comb begin
		twdl_demontr[0] = dft_size;
		for (int k = 1; k <= LAST; k++) begin
			twdl_demontr[k] = den_q[k];
		end
	end

endmodule

// File: source/mrd_param_gen.sv
//--------------------
// mixed-radix DFT parameter generator
// size table, factor latch, group sizes and twiddle chain
//--------------------
`timescale 1ns/10ps

module mrd_param_gen
	import mrd_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        sink_sop,
	input  size_idx_t   size,
	output factor_vec_t nf,
	output factor_t     num_of_factors,
	output factor_t     stage_of_rdx2,
	output pts_vec_t    dftpts_div_nf,
	output pts_vec_t    twdl_demontr
);

	// table to latch
	rom_word_t rom_q;
	logic      load_cfg;
	logic      load_aux;

	// latch to calculators
	pts_t dft_size;
	pts_t div_base;
	logic factor_5;
	logic calc_start;

	mrd_size_rom u_size_rom (.clk(clk), .rst_n(rst_n), .sink_sop(sink_sop), .size(size),
		.rom_q(rom_q), .load_cfg(load_cfg), .load_aux(load_aux));

	mrd_factor_latch u_factor_latch (.clk(clk), .rst_n(rst_n), .rom_q(rom_q),
		.load_cfg(load_cfg), .load_aux(load_aux), .nf(nf),
		.num_of_factors(num_of_factors), .stage_of_rdx2(stage_of_rdx2),
		.dft_size(dft_size), .div_base(div_base), .factor_5(factor_5),
		.calc_start(calc_start));

	mrd_stride_calc u_stride_calc (.clk(clk), .rst_n(rst_n), .calc_start(calc_start),
		.nf(nf), .dft_size(dft_size), .div_base(div_base), .factor_5(factor_5),
		.dftpts_div_nf(dftpts_div_nf));

	// chain finishes three cycles after the group sizes
	mrd_twiddle_chain u_twiddle_chain (.clk(clk), .rst_n(rst_n),
		.calc_start(calc_start), .nf(nf), .dft_size(dft_size),
		.twdl_demontr(twdl_demontr));

endmodule

// File: testbench/mrd_param_monitor.sv
//--------------------
// output monitor for the DFT parameter generator
// derives expected values from size and factors,
// compares ten cycles after each start pulse
//--------------------
`timescale 1ns/10ps
`include "mrd_params.svh"

module mrd_param_monitor
	import mrd_pkg::*;
#(
	parameter int NAME_LEN = 12
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  sink_sop,
	input  logic [8*NAME_LEN-1:0] test_name,
	input  pts_t                  exp_size,
	input  factor_vec_t           exp_factors,
	input  factor_vec_t           nf,
	input  factor_t               num_of_factors,
	input  factor_t               stage_of_rdx2,
	input  pts_vec_t              dftpts_div_nf,
	input  pts_vec_t              twdl_demontr,
	output int                    checked_count,
	output int                    pass_count,
	output int                    fail_count
);

	// sop sample edge plus nine, all outputs final
	localparam int CHECK_DELAY = 9;

	int errors;
	logic [8*NAME_LEN-1:0] name_q;
	pts_t size_q;
	factor_vec_t factors_q;

	task automatic compare_field(input logic [8*NAME_LEN-1:0] name, input string field,
		input int expected, input int actual);
		if (expected != actual) begin
			$display("CHECK FAILED %0s %0s: expected %0d, actual %0d",
				name, field, expected, actual);
			errors++;
		end
	endtask

	// -------------------
	// expected values from the factor rules
	// -------------------
	task automatic check_outputs(input logic [8*NAME_LEN-1:0] name, input pts_t sz,
		input factor_vec_t f);
		int exp_num;
		int exp_rdx2;
		int prod;
		errors = 0;
		exp_num = 0;
		// no radix-2 stage reads as 7
		exp_rdx2 = 7;
		for (int j = 0; j < `MRD_STAGES; j++) begin
			if (f[j] != 3'd1)
				exp_num++;
			if (f[j] == 3'd2 && exp_rdx2 == 7)
				exp_rdx2 = j;
		end
		// unknown size, everything cleared
		if (sz == '0) begin
			exp_num = 0;
			exp_rdx2 = 0;
		end
		for (int j = 0; j < `MRD_STAGES; j++) begin
			compare_field(name, $sformatf("nf[%0d]", j), f[j], nf[j]);
			// points per group, N / factor
			compare_field(name, $sformatf("dftpts_div_nf[%0d]", j),
				(f[j] > 3'd1) ? int'(sz) / int'(f[j]) : 0, dftpts_div_nf[j]);
		end
		compare_field(name, "num_of_factors", exp_num, num_of_factors);
		compare_field(name, "stage_of_rdx2", exp_rdx2, stage_of_rdx2);
		compare_field(name, "twdl_demontr[0]", sz, twdl_demontr[0]);
		// product of factors from the last stage down
		prod = 1;
		for (int k = `MRD_STAGES - 1; k >= 1; k--) begin
			prod = (prod * int'(f[k])) % (1 << `MRD_PTS_W);
			compare_field(name, $sformatf("twdl_demontr[%0d]", k), prod, twdl_demontr[k]);
		end
		checked_count++;
		if (errors == 0) begin
			pass_count++;
			$display("test %0s: passed", name);
		end else begin
			fail_count++;
			$display("test %0s: failed with %0d mismatches", name, errors);
		end
	endtask

	initial begin
		checked_count = 0;
		pass_count = 0;
		fail_count = 0;
		// first edge out of reset, outputs still at reset values
		do @(posedge clk); while (rst_n !== 1'b1);
		check_outputs("reset", '0, {15'd0, 3'd4});
		forever begin
			@(posedge clk);
			if (sink_sop === 1'b1) begin
				name_q = test_name;
				size_q = exp_size;
				factors_q = exp_factors;
				repeat (CHECK_DELAY) @(posedge clk);
				check_outputs(name_q, size_q, factors_q);
			end
		end
	end

endmodule

// File: testbench/mrd_param_gen_chk.sv
//--------------------
// protocol assertions for the parameter generator
//--------------------
`timescale 1ns/10ps

module mrd_param_gen_chk
	import mrd_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input logic        sink_sop,
	input factor_vec_t nf,
	input factor_t     num_of_factors,
	input factor_t     stage_of_rdx2,
	input pts_vec_t    dftpts_div_nf,
	input pts_vec_t    twdl_demontr
);

	// saturating count of cycles since the last sop
	logic [3:0] since_sop;
	logic seen_sop;
	// count of failed assertions
	int assert_errors = 0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			since_sop <= '0;
			seen_sop  <= 1'b0;
		end else if (sink_sop) begin
			since_sop <= 4'd1;
			seen_sop  <= 1'b1;
		end else if (since_sop != 4'hf) begin
			since_sop <= since_sop + 4'd1;
		end
	end

	nf0_fixed: assert property (@(posedge clk) disable iff (!rst_n) nf[0] == 3'd4)
		else begin
			$error("nf[0] is not radix 4");
			assert_errors++;
		end

	// nothing moves after the last update at t+9
	outputs_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(since_sop >= 4'd10 && !sink_sop) |-> ($stable(nf) && $stable(num_of_factors) &&
		$stable(stage_of_rdx2) && $stable(dftpts_div_nf) && $stable(twdl_demontr)))
		else begin
			$error("outputs changed after settling");
			assert_errors++;
		end

	twiddle_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_sop |-> twdl_demontr == '0)
		else begin
			$error("twiddle denominators not zero before first sop");
			assert_errors++;
		end

endmodule

bind mrd_param_gen mrd_param_gen_chk u_param_chk (.clk(clk), .rst_n(rst_n),
	.sink_sop(sink_sop), .nf(nf), .num_of_factors(num_of_factors),
	.stage_of_rdx2(stage_of_rdx2), .dftpts_div_nf(dftpts_div_nf),
	.twdl_demontr(twdl_demontr));

// File: testbench/mrd_param_gen_tb.sv
//--------------------
// testbench for the DFT parameter generator
// table of sizes applied in a loop, checked by the monitor
//--------------------
`timescale 1ns/10ps
`include "mrd_params.svh"

module mrd_param_gen_tb
	import mrd_pkg::*;
();

	localparam int NAME_LEN = 12;
	localparam int N_TESTS = 7;
	localparam int CLK_PERIOD = 20;

	// test name, size index, expected size and factors with stage 0 lowest
	typedef struct packed {
		logic [8*NAME_LEN-1:0] name;
		size_idx_t             idx;
		pts_t                  size;
		factor_vec_t           factors;
	} test_entry_t;

	test_entry_t tests [0:N_TESTS-1];

	logic clk;
	logic rst_n;
	logic sink_sop;
	size_idx_t size;
	logic [8*NAME_LEN-1:0] cur_name;
	pts_t cur_size;
	factor_vec_t cur_factors;
	factor_vec_t nf;
	factor_t num_of_factors;
	factor_t stage_of_rdx2;
	pts_vec_t dftpts_div_nf;
	pts_vec_t twdl_demontr;
	int checked_count;
	int pass_count;
	int fail_count;

	function automatic test_entry_t make_test(input logic [8*NAME_LEN-1:0] name,
		input size_idx_t idx, input pts_t sz, input factor_t f0, input factor_t f1,
		input factor_t f2, input factor_t f3, input factor_t f4, input factor_t f5);
		test_entry_t e;
		e.name = name;
		e.idx = idx;
		e.size = sz;
		e.factors = {f5, f4, f3, f2, f1, f0};
		return e;
	endfunction

	mrd_param_gen DUT (.clk(clk), .rst_n(rst_n), .sink_sop(sink_sop), .size(size),
		.nf(nf), .num_of_factors(num_of_factors), .stage_of_rdx2(stage_of_rdx2),
		.dftpts_div_nf(dftpts_div_nf), .twdl_demontr(twdl_demontr));

	mrd_param_monitor #(.NAME_LEN(NAME_LEN)) u_monitor (.clk(clk), .rst_n(rst_n),
		.sink_sop(sink_sop), .test_name(cur_name), .exp_size(cur_size),
		.exp_factors(cur_factors), .nf(nf), .num_of_factors(num_of_factors),
		.stage_of_rdx2(stage_of_rdx2), .dftpts_div_nf(dftpts_div_nf),
		.twdl_demontr(twdl_demontr), .checked_count(checked_count),
		.pass_count(pass_count), .fail_count(fail_count));

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// -------------------
	// stimulus
	// -------------------
	initial begin
		rst_n = 1'b0;
		sink_sop = 1'b0;
		size = '0;
		cur_name = '0;
		cur_size = '0;
		cur_factors = '0;
		tests[0] = make_test("size_1200", 6'd0, 12'd1200, 3'd4, 3'd4, 3'd5, 3'd5, 3'd3, 3'd1);
		tests[1] = make_test("size_1152", 6'd1, 12'd1152, 3'd4, 3'd4, 3'd4, 3'd2, 3'd3, 3'd3);
		tests[2] = make_test("size_960", 6'd2, 12'd960, 3'd4, 3'd4, 3'd4, 3'd5, 3'd3, 3'd1);
		tests[3] = make_test("size_600", 6'd3, 12'd600, 3'd4, 3'd2, 3'd5, 3'd5, 3'd3, 3'd1);
		tests[4] = make_test("size_12", 6'd4, 12'd12, 3'd4, 3'd3, 3'd1, 3'd1, 3'd1, 3'd1);
		// reload after a different size
		tests[5] = make_test("reload_1152", 6'd1, 12'd1152, 3'd4, 3'd4, 3'd4, 3'd2, 3'd3, 3'd3);
		// no table entry so outputs clear
		tests[6] = make_test("unused_33", 6'd33, 12'd0, 3'd4, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0);
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < N_TESTS; i++) begin
			sink_sop <= 1'b1;
			size <= tests[i].idx;
			cur_name <= tests[i].name;
			cur_size <= tests[i].size;
			cur_factors <= tests[i].factors;
			@(posedge clk);
			sink_sop <= 1'b0;
			repeat (12) @(posedge clk);
		end
		// reset check plus one per table entry
		wait (checked_count == N_TESTS + 1);
		$display("tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
			checked_count, pass_count, fail_count, DUT.u_param_chk.assert_errors);
		if (fail_count == 0 && DUT.u_param_chk.assert_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog allows 14 cycles per test plus margin
	initial begin
		repeat (N_TESTS*14 + 20) @(posedge clk);
		$display("timeout: monitor finished only %0d of %0d checks",
			checked_count, N_TESTS + 1);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: compile.f
+incdir+source
source/mrd_pkg.sv
source/mrd_size_rom.sv
source/mrd_factor_latch.sv
source/mrd_stride_calc.sv
source/mrd_twiddle_chain.sv
source/mrd_param_gen.sv
testbench/mrd_param_monitor.sv
testbench/mrd_param_gen_chk.sv
testbench/mrd_param_gen_tb.sv
